// File: Bender.yml
package:
  name: mmc5_prg

sources:
  # Package first, then the blocks, then the top level
  - files:
      - design/mmc5_pkg.sv
      - design/mmc5_reg_file.sv
      - design/mmc5_prg_mapper.sv
      - design/mmc5_scanline_irq.sv
      - design/mmc5_cpu_read.sv
      - design/mmc5_prg_top.sv

  # Testbench
  - target: simulation
    files:
      - dv/mmc5_prg_tb.sv

# Top modules: mmc5_prg_tb for simulation, mmc5_prg_top for the RTL

// File: design/mmc5_cpu_read.sv
// MMC5 CPU read path: status and multiplier readback, bus drive flag
`timescale 1ns/1ps
`default_nettype none

module mmc5_cpu_read (
	input  mmc5_pkg::cpu_bus_t cpu_i,
	input  mmc5_pkg::prg_cfg_t prg_cfg_i,
	input  wire                logic irq_pending_i,
	input  wire                logic in_frame_i,
	output logic [7:0]         prg_dout_o,
	output logic               prg_bus_write_o
);

	logic [15:0] product;

	assign product = prg_cfg_i.mul_a * prg_cfg_i.mul_b; // Unsigned 8x8

	always_comb begin
		prg_bus_write_o = 1'b1;
		case (cpu_i.addr)
			mmc5_pkg::REG_IRQ_STATUS: begin
				prg_dout_o = {irq_pending_i, in_frame_i, 6'b11_1111};
			end
			mmc5_pkg::REG_MUL_LO: begin
				prg_dout_o = product[7:0];
			end
			mmc5_pkg::REG_MUL_HI: begin
				prg_dout_o = product[15:8];
			end
			default: begin
				prg_dout_o      = 8'hFF; // Open bus
				prg_bus_write_o = 1'b0;
			end
		endcase
	end

endmodule

`default_nettype wire

// File: design/mmc5_pkg.sv
// MMC5 PRG side shared types: CPU and PPU bus cycles, configuration, register map
`default_nettype none

package mmc5_pkg;

	// One CPU bus cycle as seen by the mapper
	typedef struct packed {
		logic        ce;    // M2 strobe, one clk per CPU cycle
		logic        read;
		logic        write;
		logic [15:0] addr;
		logic [7:0]  wdata;
	} cpu_bus_t;

	// PPU fetch, single merged CHR address
	typedef struct packed {
		logic [13:0] chr_addr;
		logic        chr_read; // Level, high during a PPU read
	} ppu_bus_t;

	// PRG banking and multiplier operands
	typedef struct packed {
		logic [1:0] prg_mode;
		logic       protect_1;
		logic       protect_2;
		logic [2:0] ram_bank;
		logic [7:0] bank_0;
		logic [7:0] bank_1;
		logic [7:0] bank_2;
		logic [6:0] bank_3;  // Always ROM, no marker bit
		logic [7:0] mul_a;
		logic [7:0] mul_b;
	} prg_cfg_t;

	// Scanline compare IRQ setup
	typedef struct packed {
		logic [7:0] irq_scanline;
		logic       irq_enable;
	} irq_cfg_t;

	typedef logic [21:0] prg_addr_t;

	// Register map
	localparam logic [15:0] REG_PRG_MODE   = 16'h5100;
	localparam logic [15:0] REG_PROTECT_1  = 16'h5102;
	localparam logic [15:0] REG_PROTECT_2  = 16'h5103;
	localparam logic [15:0] REG_RAM_BANK   = 16'h5113;
	localparam logic [15:0] REG_BANK_0     = 16'h5114;
	localparam logic [15:0] REG_BANK_1     = 16'h5115;
	localparam logic [15:0] REG_BANK_2     = 16'h5116;
	localparam logic [15:0] REG_BANK_3     = 16'h5117;
	localparam logic [15:0] REG_IRQ_LINE   = 16'h5203;
	localparam logic [15:0] REG_IRQ_STATUS = 16'h5204; // Write sets enable, read gives status
	localparam logic [15:0] REG_MUL_LO     = 16'h5205;
	localparam logic [15:0] REG_MUL_HI     = 16'h5206;

	// Special CPU addresses
	localparam logic [15:0] NMI_VECTOR   = 16'hFFFA; // $FFFB matches as well
	localparam logic [15:0] PRG_RAM_BASE = 16'h6000;

	// PRG output address layout
	localparam logic [5:0] RAM_REGION = 6'h3C; // Save RAM sits at the top of the 4 MB space
	localparam int         PRG_PAGE_W = 13;    // 8 kB page offset

	// Scanline detector limits
	localparam logic [7:0] LAST_SCANLINE = 8'd239;
	localparam logic [1:0] IDLE_STROBES  = 2'd3;

endpackage

`default_nettype wire

// File: design/mmc5_prg_mapper.sv
// MMC5 PRG mapper: CPU address to 22-bit PRG memory address plus access allow
`timescale 1ns/1ps
`default_nettype none

module mmc5_prg_mapper (
	input  mmc5_pkg::cpu_bus_t  cpu_i,
	input  mmc5_pkg::prg_cfg_t  prg_cfg_i,
	output mmc5_pkg::prg_addr_t prg_aout_o,
	output wire logic           prg_allow_o
);

	logic [7:0] page;   // Bit 7 high selects ROM
	logic       is_rom;
	logic       ram_we;

	always_comb begin
		casez ({prg_cfg_i.prg_mode, cpu_i.addr[15:13]})
			// $6000-$7FFF in every mode
			5'b??_0??: page = {5'b0_0000, prg_cfg_i.ram_bank};
			// Mode 0, one 32 kB page
			5'b00_1??: page = {1'b1, prg_cfg_i.bank_3[6:2], cpu_i.addr[14:13]};
			// Mode 1, two 16 kB pages
			5'b01_10?: page = {prg_cfg_i.bank_1[7:1], cpu_i.addr[13]};
			5'b01_11?: page = {1'b1, prg_cfg_i.bank_3[6:1], cpu_i.addr[13]};
			// Mode 2, 16 kB + 8 kB + 8 kB
			5'b10_10?: page = {prg_cfg_i.bank_1[7:1], cpu_i.addr[13]};
			5'b10_110: page = prg_cfg_i.bank_2;
			5'b10_111: page = {1'b1, prg_cfg_i.bank_3};
			// Mode 3, four 8 kB pages
			5'b11_100: page = prg_cfg_i.bank_0;
			5'b11_101: page = prg_cfg_i.bank_1;
			5'b11_110: page = prg_cfg_i.bank_2;
			5'b11_111: page = {1'b1, prg_cfg_i.bank_3};
			default:   page = {5'b0_0000, prg_cfg_i.ram_bank};
		endcase
	end

	assign is_rom = page[7];

	always_comb begin
		if (is_rom) begin
			prg_aout_o = {2'b00, page[6:0], cpu_i.addr[mmc5_pkg::PRG_PAGE_W-1:0]};
		end else begin
			prg_aout_o = {mmc5_pkg::RAM_REGION, prg_cfg_i.ram_bank,
				cpu_i.addr[mmc5_pkg::PRG_PAGE_W-1:0]};
		end
	end

	// Both protect registers must be unlocked for any RAM write
	assign ram_we = prg_cfg_i.protect_1 && prg_cfg_i.protect_2;

	assign prg_allow_o = (cpu_i.addr >= mmc5_pkg::PRG_RAM_BASE) &&
		(!cpu_i.write || (!is_rom && ram_we));

endmodule

`default_nettype wire

// File: design/mmc5_prg_top.sv
// MMC5 CPU-side top: register file, PRG mapper, scanline IRQ and read path
`timescale 1ns/1ps
`default_nettype none

module mmc5_prg_top (
	input  wire                 logic clk,
	input  wire                 logic rst_n_i,
	input  mmc5_pkg::cpu_bus_t  cpu_i,
	input  mmc5_pkg::ppu_bus_t  ppu_i,
	output mmc5_pkg::prg_addr_t prg_aout_o,
	output wire                 logic prg_allow_o,
	output logic [7:0]          prg_dout_o,
	output wire                 logic prg_bus_write_o,
	output wire                 logic irq_o
);

	mmc5_pkg::prg_cfg_t prg_cfg;
	mmc5_pkg::irq_cfg_t irq_cfg;
	logic               irq_pending;
	logic               in_frame;

	mmc5_reg_file u_reg_file (
		.clk       (clk),
		.rst_n_i   (rst_n_i),
		.cpu_i     (cpu_i),
		.prg_cfg_o (prg_cfg),
		.irq_cfg_o (irq_cfg)
	);

	mmc5_prg_mapper u_prg_mapper (
		.cpu_i       (cpu_i),
		.prg_cfg_i   (prg_cfg),
		.prg_aout_o  (prg_aout_o),
		.prg_allow_o (prg_allow_o)
	);

	mmc5_scanline_irq u_scanline_irq (
		.clk           (clk),
		.rst_n_i       (rst_n_i),
		.cpu_i         (cpu_i),
		.ppu_i         (ppu_i),
		.irq_cfg_i     (irq_cfg),
		.irq_o         (irq_o),
		.irq_pending_o (irq_pending),
		.in_frame_o    (in_frame)
	);

	mmc5_cpu_read u_cpu_read (
		.cpu_i           (cpu_i),
		.prg_cfg_i       (prg_cfg),
		.irq_pending_i   (irq_pending),
		.in_frame_i      (in_frame),
		.prg_dout_o      (prg_dout_o),
		.prg_bus_write_o (prg_bus_write_o)
	);

endmodule

`default_nettype wire

// File: design/mmc5_reg_file.sv
// MMC5 register file: decodes CPU writes into PRG, IRQ and multiplier settings
`timescale 1ns/1ps
`default_nettype none

module mmc5_reg_file (
	input  wire                logic clk,
	input  wire                logic rst_n_i,
	input  mmc5_pkg::cpu_bus_t cpu_i,
	output mmc5_pkg::prg_cfg_t prg_cfg_o,
	output mmc5_pkg::irq_cfg_t irq_cfg_o
);

	mmc5_pkg::prg_cfg_t prg_cfg_q;
	mmc5_pkg::irq_cfg_t irq_cfg_q;

	logic wr_stb;

	assign wr_stb = cpu_i.ce && cpu_i.write;

	always_ff @(posedge clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			prg_cfg_q.prg_mode  <= 2'd3; // Boot in 8 kB mode so the vectors hit bank 3
			prg_cfg_q.protect_1 <= 1'b0;
			prg_cfg_q.protect_2 <= 1'b0;
			prg_cfg_q.ram_bank  <= 3'd0;
			prg_cfg_q.bank_0    <= 8'd0;
			prg_cfg_q.bank_1    <= 8'd0;
			prg_cfg_q.bank_2    <= 8'd0;
			prg_cfg_q.bank_3    <= 7'h7F; // Last ROM page
			prg_cfg_q.mul_a     <= 8'd0;
			prg_cfg_q.mul_b     <= 8'd0;
			irq_cfg_q           <= '0;
		end else if (wr_stb) begin
			case (cpu_i.addr)
				mmc5_pkg::REG_PRG_MODE: begin
					prg_cfg_q.prg_mode <= cpu_i.wdata[1:0];
				end
				// Protects only unlock on their magic values
				mmc5_pkg::REG_PROTECT_1: begin
					prg_cfg_q.protect_1 <= (cpu_i.wdata[1:0] == 2'b10);
				end
				mmc5_pkg::REG_PROTECT_2: begin
					prg_cfg_q.protect_2 <= (cpu_i.wdata[1:0] == 2'b01);
				end
				mmc5_pkg::REG_RAM_BANK: begin
					prg_cfg_q.ram_bank <= cpu_i.wdata[2:0];
				end
				mmc5_pkg::REG_BANK_0: begin
					prg_cfg_q.bank_0 <= cpu_i.wdata;
				end
				mmc5_pkg::REG_BANK_1: begin
					prg_cfg_q.bank_1 <= cpu_i.wdata;
				end
				mmc5_pkg::REG_BANK_2: begin
					prg_cfg_q.bank_2 <= cpu_i.wdata;
				end
				mmc5_pkg::REG_BANK_3: begin
					prg_cfg_q.bank_3 <= cpu_i.wdata[6:0]; // Bit 7 ignored, always ROM
				end
				mmc5_pkg::REG_IRQ_LINE: begin
					irq_cfg_q.irq_scanline <= cpu_i.wdata;
				end
				mmc5_pkg::REG_IRQ_STATUS: begin
					irq_cfg_q.irq_enable <= cpu_i.wdata[7];
				end
				mmc5_pkg::REG_MUL_LO: begin
					prg_cfg_q.mul_a <= cpu_i.wdata;
				end
				mmc5_pkg::REG_MUL_HI: begin
					prg_cfg_q.mul_b <= cpu_i.wdata;
				end
				default: begin
				end
			endcase
		end
	end

	assign prg_cfg_o = prg_cfg_q;
	assign irq_cfg_o = irq_cfg_q;

	// The CPU fetches its reset vector right after release, so mode 3 must hold then
	a_boot_mode: assert property (@(posedge clk)
		$rose(rst_n_i) |=> prg_cfg_q.prg_mode == 2'd3)
		else $error("PRG mode not 3 after reset release");

endmodule

`default_nettype wire

// File: design/mmc5_scanline_irq.sv
// MMC5 scanline detector: frame and scanline tracking from PPU reads, IRQ pending flag
`timescale 1ns/1ps
`default_nettype none

module mmc5_scanline_irq (
	input  wire                logic clk,
	input  wire                logic rst_n_i,
	input  mmc5_pkg::cpu_bus_t cpu_i,
	input  mmc5_pkg::ppu_bus_t ppu_i,
	input  mmc5_pkg::irq_cfg_t irq_cfg_i,
	output wire                logic irq_o,
	output wire                logic irq_pending_o,
	output wire                logic in_frame_o
);

	logic        chr_read_q;
	logic [11:0] last_nt_addr;
	logic [1:0]  nt_read_cnt;  // Saturates at 3
	logic [1:0]  idle_cnt;     // CPU strobes without a PPU read
	logic        in_frame;
	logic [7:0]  scanline;
	logic        irq_pending;
	logic        irq_clear;    // Armed by a status read

	logic ppu_edge;
	logic is_nt;
	logic nt_mismatch;
	logic nt_full;
	logic vector_read;
	logic status_read;
	logic idle_exit;
	logic line_exit;
	logic leave_frame;

	assign ppu_edge    = ppu_i.chr_read && !chr_read_q;
	assign is_nt       = (ppu_i.chr_addr[13:12] == 2'b10);
	assign nt_mismatch = (nt_read_cnt != 2'd0) && (last_nt_addr != ppu_i.chr_addr[11:0]);
	assign nt_full     = (nt_read_cnt == 2'd3);

	// $FFFA/$FFFB, NMI vector fetch means the PPU is in vblank
	assign vector_read = cpu_i.ce && cpu_i.read &&
		({cpu_i.addr[15:1], 1'b0} == mmc5_pkg::NMI_VECTOR);
	assign status_read = cpu_i.ce && cpu_i.read && (cpu_i.addr == mmc5_pkg::REG_IRQ_STATUS);

	assign idle_exit = cpu_i.ce && !ppu_i.chr_read && in_frame &&
		(idle_cnt + 2'd1 == mmc5_pkg::IDLE_STROBES);
	assign line_exit = ppu_edge && nt_full && in_frame &&
		(scanline == mmc5_pkg::LAST_SCANLINE);

	assign leave_frame = vector_read || idle_exit || line_exit;

	always_ff @(posedge clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			chr_read_q   <= 1'b0;
			last_nt_addr <= 12'd0;
			nt_read_cnt  <= 2'd0;
			idle_cnt     <= 2'd0;
			in_frame     <= 1'b0;
			scanline     <= 8'd0;
			irq_pending  <= 1'b0;
			irq_clear    <= 1'b0;
		end else begin
			chr_read_q <= ppu_i.chr_read;

			if (ppu_edge) begin
				last_nt_addr <= ppu_i.chr_addr[11:0];
				if (!nt_full) begin
					nt_read_cnt <= nt_read_cnt + 2'd1;
				end else if (!in_frame) begin
					in_frame <= 1'b1; // First line of a new frame
					scanline <= 8'd0;
				end else if (scanline != mmc5_pkg::LAST_SCANLINE) begin
					scanline <= scanline + 8'd1;
					if (scanline + 8'd1 == irq_cfg_i.irq_scanline)
						irq_pending <= 1'b1;
				end
				if (!is_nt || nt_mismatch)
					nt_read_cnt <= 2'd0;
			end

			if (ppu_i.chr_read) begin
				idle_cnt <= 2'd0;
			end else if (cpu_i.ce && in_frame) begin
				idle_cnt <= idle_cnt + 2'd1;
			end

			// Pending drops on the strobe after the status read
			if (cpu_i.ce) begin
				irq_clear <= status_read;
				if (irq_clear)
					irq_pending <= 1'b0;
			end

			if (leave_frame) begin
				in_frame    <= 1'b0;
				nt_read_cnt <= 2'd0;
				idle_cnt    <= 2'd0;
				irq_pending <= 1'b0;
			end
		end
	end

	assign irq_o         = irq_pending && irq_cfg_i.irq_enable;
	assign irq_pending_o = irq_pending;
	assign in_frame_o    = in_frame;

	// Line 239 always exits the frame before the count can pass it
	a_scanline_max: assert property (@(posedge clk) disable iff (!rst_n_i)
		scanline <= mmc5_pkg::LAST_SCANLINE)
		else $error("Scanline count passed 239");

endmodule

`default_nettype wire

// File: dv/mmc5_prg_tb.sv
// MMC5 PRG testbench: directed tests for banking, allow rule, multiplier and scanline IRQ
`timescale 1ns/1ps
`default_nettype none

module mmc5_prg_tb;

	localparam int CLK_PERIOD = 10;
	// Mode sweep is the longest test at roughly 4 x (6 writes + 10 probes) x 2 cycles,
	// the rest add a few hundred cycles, so this leaves a wide margin
	localparam int TIMEOUT_CYCLES = 20000;

	logic                clk;
	logic                rst_n;
	mmc5_pkg::cpu_bus_t  cpu;
	mmc5_pkg::ppu_bus_t  ppu;
	mmc5_pkg::prg_addr_t prg_aout;
	logic                prg_allow;
	logic [7:0]          prg_dout;
	logic                prg_bus_write;
	logic                irq;

	int    cycles;
	int    errors;
	int    test_errors;
	int    tests_run;
	int    tests_failed;
	string cur_test;

	// Expected banking state, tracked from the writes the tests make
	logic [1:0] sh_mode;
	logic [2:0] sh_ram;
	logic [7:0] sh_b0;
	logic [7:0] sh_b1;
	logic [7:0] sh_b2;
	logic [6:0] sh_b3;

	mmc5_prg_top dut0 (
		.clk             (clk),
		.rst_n_i         (rst_n),
		.cpu_i           (cpu),
		.ppu_i           (ppu),
		.prg_aout_o      (prg_aout),
		.prg_allow_o     (prg_allow),
		.prg_dout_o      (prg_dout),
		.prg_bus_write_o (prg_bus_write),
		.irq_o           (irq)
	);

	always #(CLK_PERIOD / 2) clk = ~clk;

	always @(posedge clk) begin
		cycles++;
		if (cycles >= TIMEOUT_CYCLES) begin
			$display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
			$display("SIMULATION FAILED");
			$finish;
		end
	end

	task automatic check_val(input string name, input logic [31:0] exp, input logic [31:0] act);
		assert (act === exp)
		else begin
			$display("ERROR %s: %s expected %h actual %h", cur_test, name, exp, act);
			errors++;
			test_errors++;
		end
	endtask

	task automatic finish_test(input string name);
		tests_run++;
		if (test_errors == 0) begin
			$display("test %s: ok", name);
		end else begin
			$display("test %s: %0d errors", name, test_errors);
			tests_failed++;
		end
		test_errors = 0;
	endtask

	task automatic cpu_write(input logic [15:0] addr, input logic [7:0] data);
		@(negedge clk);
		cpu.ce    = 1'b1;
		cpu.read  = 1'b0;
		cpu.write = 1'b1;
		cpu.addr  = addr;
		cpu.wdata = data;
		@(negedge clk);
		cpu = '0;
	endtask

	// Samples mid low phase, before the strobe's clk edge
	task automatic cpu_read(input logic [15:0] addr, output logic [7:0] data, output logic drv);
		@(negedge clk);
		cpu.ce    = 1'b1;
		cpu.read  = 1'b1;
		cpu.write = 1'b0;
		cpu.addr  = addr;
		cpu.wdata = 8'h00;
		#2;
		data = prg_dout;
		drv  = prg_bus_write;
		@(negedge clk);
		cpu = '0;
	endtask

	// Address and direction only, ce stays low so no register sees it
	task automatic probe_addr(input logic [15:0] addr, input logic wr);
		@(negedge clk);
		cpu.ce    = 1'b0;
		cpu.read  = !wr;
		cpu.write = wr;
		cpu.addr  = addr;
		cpu.wdata = 8'h00;
		#2;
	endtask

	task automatic ppu_read(input logic [13:0] addr);
		@(negedge clk);
		cpu          = '0; // ce low keeps the idle count at zero
		ppu.chr_addr = addr;
		ppu.chr_read = 1'b1;
		repeat (2) @(negedge clk);
		ppu.chr_read = 1'b0;
	endtask

	task automatic idle_strobes(input int n);
		repeat (n) begin
			@(negedge clk);
			cpu    = '0;
			cpu.ce = 1'b1;
			@(negedge clk);
			cpu.ce = 1'b0;
		end
	endtask

	function automatic mmc5_pkg::prg_addr_t expected_aout(input logic [15:0] addr);
		logic [7:0] page;
		if (addr < 16'h8000) begin
			page = {5'd0, sh_ram};
		end else begin
			case (sh_mode)
				2'd0: page = {1'b1, sh_b3[6:2], addr[14:13]};
				2'd1: page = (addr < 16'hC000) ? {sh_b1[7:1], addr[13]} :
					{1'b1, sh_b3[6:1], addr[13]};
				2'd2: begin
					if (addr < 16'hC000)
						page = {sh_b1[7:1], addr[13]};
					else if (addr < 16'hE000)
						page = sh_b2;
					else
						page = {1'b1, sh_b3};
				end
				default: begin
					case (addr[14:13])
						2'd0: page = sh_b0;
						2'd1: page = sh_b1;
						2'd2: page = sh_b2;
						default: page = {1'b1, sh_b3};
					endcase
				end
			endcase
		end
		if (page[7])
			return {2'b00, page[6:0], addr[12:0]};
		return {6'h3C, sh_ram, addr[12:0]}; // Save RAM region
	endfunction

	task automatic test_reset_map();
		logic [12:0] off;
		logic [7:0]  d;
		logic        drv;
		cur_test = "reset_map";
		off = 13'($urandom);
		probe_addr({3'b111, off}, 1'b0);
		check_val("reset_map aout", {2'b00, 7'h7F, off}, prg_aout);
		cpu_read(16'h5204, d, drv);
		check_val("reset_map status", 8'h3F, d);
		check_val("reset_map irq", 1'b0, irq);
		finish_test("reset_map");
	endtask

	task automatic test_prg_modes();
		logic [15:0] addr;
		cur_test = "prg_modes";
		for (int m = 0; m < 4; m++) begin
			sh_mode = 2'(m);
			sh_ram  = 3'($urandom);
			sh_b0   = 8'($urandom);
			sh_b1   = 8'($urandom);
			sh_b2   = 8'($urandom);
			sh_b3   = 7'($urandom);
			cpu_write(16'h5100, {6'd0, sh_mode});
			cpu_write(16'h5113, {5'd0, sh_ram});
			cpu_write(16'h5114, sh_b0);
			cpu_write(16'h5115, sh_b1);
			cpu_write(16'h5116, sh_b2);
			cpu_write(16'h5117, {$urandom % 2 == 0, sh_b3}); // Bit 7 must not matter
			for (int w = 3; w < 8; w++) begin
				repeat (2) begin
					addr = {3'(w), 13'($urandom)};
					probe_addr(addr, 1'b0);
					check_val($sformatf("mode%0d aout %h", m, addr), expected_aout(addr), prg_aout);
					check_val($sformatf("mode%0d allow %h", m, addr), 1'b1, prg_allow);
				end
			end
		end
		finish_test("prg_modes");
	endtask

	task automatic test_allow_rule();
		cur_test = "allow_rule";
		cpu_write(16'h5100, 8'h03);
		probe_addr(16'h6000, 1'b1);
		check_val("allow locked ram write", 1'b0, prg_allow);
		cpu_write(16'h5102, 8'h02);
		probe_addr(16'h6000, 1'b1);
		check_val("allow half unlocked", 1'b0, prg_allow);
		cpu_write(16'h5103, 8'h01);
		probe_addr(16'h7FFF, 1'b1);
		check_val("allow unlocked ram write", 1'b1, prg_allow);
		probe_addr(16'hE123, 1'b1);
		check_val("allow rom write", 1'b0, prg_allow);
		probe_addr(16'h6000, 1'b0);
		check_val("allow read 6000", 1'b1, prg_allow);
		probe_addr(16'h5FFF, 1'b0);
		check_val("allow read 5fff", 1'b0, prg_allow);
		finish_test("allow_rule");
	endtask

	task automatic test_multiplier();
		logic [7:0]  a;
		logic [7:0]  b;
		logic [15:0] prod;
		logic [7:0]  d;
		logic        drv;
		cur_test = "multiplier";
		repeat (20) begin
			a    = 8'($urandom);
			b    = 8'($urandom);
			prod = {8'd0, a} * {8'd0, b};
			cpu_write(16'h5205, a);
			cpu_write(16'h5206, b);
			cpu_read(16'h5205, d, drv);
			check_val($sformatf("mul lo %h*%h", a, b), prod[7:0], d);
			check_val("mul lo drive", 1'b1, drv);
			cpu_read(16'h5206, d, drv);
			check_val($sformatf("mul hi %h*%h", a, b), prod[15:8], d);
			check_val("mul hi drive", 1'b1, drv);
		end
		finish_test("multiplier");
	endtask

	task automatic test_scanline_irq();
		logic [7:0] d;
		logic       drv;
		cur_test = "scanline_irq";
		cpu_write(16'h5203, 8'd3);
		cpu_write(16'h5204, 8'h80);
		repeat (4) ppu_read(14'h2000);
		cpu_read(16'h5204, d, drv);
		check_val("irq in_frame", 8'h7F, d);
		repeat (3) ppu_read(14'h2000); // Scanlines 1 to 3
		check_val("irq raised", 1'b1, irq);
		cpu_read(16'h5204, d, drv);
		check_val("irq status pending", 8'hFF, d);
		idle_strobes(1);
		check_val("irq cleared", 1'b0, irq);
		finish_test("scanline_irq");
	endtask

	task automatic test_frame_exit();
		logic [7:0] d;
		logic       drv;
		cur_test = "frame_exit";
		ppu_read(14'h2000);
		idle_strobes(3);
		cpu_read(16'h5204, d, drv);
		check_val("exit idle status", 8'h3F, d);
		repeat (4) ppu_read(14'h2000);
		cpu_read(16'h5204, d, drv);
		check_val("reenter status", 8'h7F, d);
		cpu_read(16'hFFFA, d, drv);
		check_val("vector read drive", 1'b0, drv);
		cpu_read(16'h5204, d, drv);
		check_val("exit vector status", 8'h3F, d);
		finish_test("frame_exit");
	endtask

	initial begin
		clk          = 1'b0;
		rst_n        = 1'b0;
		cpu          = '0;
		ppu          = '0;
		cycles       = 0;
		errors       = 0;
		test_errors  = 0;
		tests_run    = 0;
		tests_failed = 0;
		cur_test     = "reset";
		void'($urandom(56643));
		sh_mode      = 2'd3;
		sh_ram       = 3'd0;
		sh_b0        = 8'd0;
		sh_b1        = 8'd0;
		sh_b2        = 8'd0;
		sh_b3        = 7'h7F;
		repeat (10) @(negedge clk);
		rst_n = 1'b1;

		test_reset_map();
		test_prg_modes();
		test_allow_rule();
		test_multiplier();
		test_scanline_irq();
		test_frame_exit();

		$display("tests run %0d, tests failed %0d, errors %0d", tests_run, tests_failed, errors);
		if (errors == 0) begin
			$display("SIMULATION PASSED");
		end else begin
			$display("SIMULATION FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: mmc5_prg_top.f
design/mmc5_pkg.sv
design/mmc5_reg_file.sv
design/mmc5_prg_mapper.sv
design/mmc5_scanline_irq.sv
design/mmc5_cpu_read.sv
design/mmc5_prg_top.sv
dv/mmc5_prg_tb.sv
